/* design/exe_pkg.sv */
package exe_pkg;

    // --------------------
    // alu operation word, one bit per operation
    localparam int aluop_w = 12;

    localparam int op_add  = 0;
    localparam int op_sub  = 1;
    localparam int op_slt  = 2;
    localparam int op_sltu = 3;
    localparam int op_and  = 4;
    localparam int op_nor  = 5;
    localparam int op_or   = 6;
    localparam int op_xor  = 7;
    localparam int op_sll  = 8;
    localparam int op_srl  = 9;
    localparam int op_sra  = 10;
    localparam int op_lui  = 11;

    // --------------------
    // store form, picks lane placement
    typedef enum logic [2:0] {
        st_none,
        st_sb,
        st_sh,
        st_sw,
        st_swl,
        st_swr
    } store_kind_t;

    // which alignment rule applies to the access
    typedef enum logic [2:0] {
        chk_none,
        chk_load_half,
        chk_load_word,
        chk_store_half,
        chk_store_word
    } check_kind_t;

    // --------------------
    typedef logic [4:0] exc_code_t;    // upstream codes pass through unchanged

    localparam exc_code_t exc_adel = 5'd4;     // address error, load
    localparam exc_code_t exc_ades = 5'd5;     // address error, store
    localparam exc_code_t exc_ov   = 5'd12;    // arithmetic overflow

endpackage

/* design/exe_issue_reg.sv */
`timescale 1ns/1ps

module exe_issue_reg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         in_valid,
    input  logic                         mem_allowin,
    input  logic [exe_pkg::aluop_w-1:0]  in_aluop,
    input  logic                         in_ov_trap,
    input  logic [31:0]                  in_src0,
    input  logic [31:0]                  in_src1,
    input  logic [31:0]                  in_store_data,
    input  exe_pkg::store_kind_t         in_store_kind,
    input  exe_pkg::check_kind_t         in_check_kind,
    input  logic [4:0]                   in_wnum,
    input  logic [31:0]                  in_pc,
    input  logic                         in_exc,
    input  exe_pkg::exc_code_t           in_exc_code,
    input  logic [31:0]                  in_bad_vaddr,
    output logic                         allowin,
    output logic                         stage_valid,
    output logic [exe_pkg::aluop_w-1:0]  r_aluop,
    output logic                         r_ov_trap,
    output logic [31:0]                  r_src0,
    output logic [31:0]                  r_src1,
    output logic [31:0]                  r_store_data,
    output exe_pkg::store_kind_t         r_store_kind,
    output exe_pkg::check_kind_t         r_check_kind,
    output logic [4:0]                   r_wnum,
    output logic [31:0]                  r_pc,
    output logic                         r_exc,
    output exe_pkg::exc_code_t           r_exc_code,
    output logic [31:0]                  r_bad_vaddr
);

    logic take;    // new instruction captured this edge

    // empty stage, or the current one leaves this cycle
    assign allowin = !stage_valid || mem_allowin;
    assign take    = allowin && in_valid && !flush;

    // --------------------
    // valid bit
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stage_valid <= 1'b0;
        end else if (allowin) begin
            stage_valid <= in_valid;
        end
    end

    // control fields go neutral when the slot is empty
    always_ff @(posedge clk) begin
        if (rst || flush || (allowin && !in_valid)) begin
            r_aluop      <= '0;
            r_ov_trap    <= 1'b0;
            r_store_kind <= exe_pkg::st_none;
            r_check_kind <= exe_pkg::chk_none;
            r_wnum       <= 5'd0;
            r_exc        <= 1'b0;
        end else if (take) begin
            r_aluop      <= in_aluop;
            r_ov_trap    <= in_ov_trap;
            r_store_kind <= in_store_kind;
            r_check_kind <= in_check_kind;
            r_wnum       <= in_wnum;
            r_exc        <= in_exc;
        end
    end

    // --------------------
    // payload, loaded only on accept
    always_ff @(posedge clk) begin
        if (take) begin
            r_src0       <= in_src0;
            r_src1       <= in_src1;
            r_store_data <= in_store_data;
            r_pc         <= in_pc;
            r_exc_code   <= in_exc_code;
            r_bad_vaddr  <= in_bad_vaddr;
        end
    end

endmodule

/* design/exe_alu.sv */
`timescale 1ns/1ps

module exe_alu (
    input  logic [exe_pkg::aluop_w-1:0]  aluop,
    input  logic                         ov_trap,
    input  logic [31:0]                  src0,
    input  logic [31:0]                  src1,
    output logic [31:0]                  result,
    output logic                         overflow
);

    logic        sub_like;     // adder runs as a subtractor
    logic [31:0] b_eff;
    logic [32:0] sum_c;
    logic [31:0] sum;
    logic        ov_raw;
    logic        slt_bit;
    logic        sltu_bit;
    logic [4:0]  sa;           // shift amount

    // --------------------
    // shared adder for add, sub, slt, sltu
    assign sub_like = aluop[exe_pkg::op_sub] | aluop[exe_pkg::op_slt]
                    | aluop[exe_pkg::op_sltu];
    assign b_eff    = sub_like ? ~src1 : src1;
    assign sum_c    = {1'b0, src0} + {1'b0, b_eff} + {32'd0, sub_like};
    assign sum      = sum_c[31:0];

    // same-sign operands, result sign flipped
    assign ov_raw   = (src0[31] == b_eff[31]) && (sum[31] != src0[31]);
    assign slt_bit  = sum[31] ^ ov_raw;
    assign sltu_bit = ~sum_c[32];    // borrow out

    assign sa = src0[4:0];

    // --------------------
    // one-hot select, and-or of every candidate
    always_comb begin
        result = ({32{aluop[exe_pkg::op_add]}}  & sum)
               | ({32{aluop[exe_pkg::op_sub]}}  & sum)
               | ({32{aluop[exe_pkg::op_slt]}}  & {31'd0, slt_bit})
               | ({32{aluop[exe_pkg::op_sltu]}} & {31'd0, sltu_bit})
               | ({32{aluop[exe_pkg::op_and]}}  & (src0 & src1))
               | ({32{aluop[exe_pkg::op_nor]}}  & ~(src0 | src1))
               | ({32{aluop[exe_pkg::op_or]}}   & (src0 | src1))
               | ({32{aluop[exe_pkg::op_xor]}}  & (src0 ^ src1))
               | ({32{aluop[exe_pkg::op_sll]}}  & (src1 << sa))
               | ({32{aluop[exe_pkg::op_srl]}}  & (src1 >> sa))
               | ({32{aluop[exe_pkg::op_sra]}}  & 32'($signed(src1) >>> sa))
               | ({32{aluop[exe_pkg::op_lui]}}  & {src1[15:0], 16'd0});
    end

    // only trapping add/sub report it
    assign overflow = ov_trap && ov_raw
                   && (aluop[exe_pkg::op_add] || aluop[exe_pkg::op_sub]);

endmodule

/* design/exe_store_align.sv */
`timescale 1ns/1ps

module exe_store_align (
    input  exe_pkg::store_kind_t  store_kind,
    input  logic [1:0]            addr_low,
    input  logic [31:0]           store_data,
    output logic [31:0]           dm_data,
    output logic [3:0]            byte_we
);

    logic [4:0] left_sh;     // 8*(3-a) for swl
    logic [4:0] right_sh;    // 8*a for swr

    // 3-a on two bits is just the inverse
    assign left_sh  = {~addr_low, 3'b000};
    assign right_sh = {addr_low, 3'b000};

    // --------------------
    // lane placement, little-endian
    always_comb begin
        dm_data = store_data;
        byte_we = 4'b0000;
        case (store_kind)
            exe_pkg::st_sb: begin
                dm_data = {4{store_data[7:0]}};
                byte_we = 4'b0001 << addr_low;
            end
            exe_pkg::st_sh: begin
                dm_data = {2{store_data[15:0]}};
                byte_we = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            exe_pkg::st_sw: begin
                byte_we = 4'b1111;
            end
            exe_pkg::st_swl: begin
                // high part of the register lands in lanes 0..a
                dm_data = store_data >> left_sh;
                case (addr_low)
                    2'd0:    byte_we = 4'b0001;
                    2'd1:    byte_we = 4'b0011;
                    2'd2:    byte_we = 4'b0111;
                    default: byte_we = 4'b1111;
                endcase
            end
            exe_pkg::st_swr: begin
                // low part lands in lanes a..3
                dm_data = store_data << right_sh;
                case (addr_low)
                    2'd0:    byte_we = 4'b1111;
                    2'd1:    byte_we = 4'b1110;
                    2'd2:    byte_we = 4'b1100;
                    default: byte_we = 4'b1000;
                endcase
            end
            default: begin
                byte_we = 4'b0000;    // not a store
            end
        endcase
    end

endmodule

/* design/exe_mem_out.sv */
`timescale 1ns/1ps

module exe_mem_out (
    input  logic                  stage_valid,
    input  exe_pkg::check_kind_t  check_kind,
    input  logic [31:0]           result,
    input  logic                  overflow,
    input  logic [3:0]            byte_we,
    input  logic [31:0]           aligned_data,
    input  logic [4:0]            r_wnum,
    input  logic [31:0]           r_pc,
    input  logic                  r_exc,
    input  exe_pkg::exc_code_t    r_exc_code,
    input  logic [31:0]           r_bad_vaddr,
    output logic                  out_valid,
    output logic [31:0]           alu_result,
    output logic [31:0]           dm_addr,
    output logic [31:0]           dm_data,
    output logic [3:0]            dm_we,
    output logic [4:0]            wnum,
    output logic [31:0]           pc,
    output logic                  exception,
    output exe_pkg::exc_code_t    exc_code,
    output logic [31:0]           bad_vaddr
);

    logic               half_bad;
    logic               word_bad;
    logic               addr_err;
    exe_pkg::exc_code_t addr_code;

    assign half_bad = result[0];
    assign word_bad = |result[1:0];

    // --------------------
    // alignment check
    always_comb begin
        addr_err  = 1'b0;
        addr_code = exe_pkg::exc_adel;
        case (check_kind)
            exe_pkg::chk_load_half:  addr_err = half_bad;
            exe_pkg::chk_load_word:  addr_err = word_bad;
            exe_pkg::chk_store_half: begin
                addr_err  = half_bad;
                addr_code = exe_pkg::exc_ades;
            end
            exe_pkg::chk_store_word: begin
                addr_err  = word_bad;
                addr_code = exe_pkg::exc_ades;
            end
            default: addr_err = 1'b0;
        endcase
    end

    // --------------------
    // exception merge, upstream first, then overflow, then address
    assign exception = r_exc || overflow || addr_err;
    assign exc_code  = r_exc    ? r_exc_code
                     : overflow ? exe_pkg::exc_ov
                     : addr_code;
    assign bad_vaddr = r_exc ? r_bad_vaddr : result;

    // --------------------
    // memory request
    assign out_valid  = stage_valid;
    assign dm_addr    = result;
    assign dm_data    = aligned_data;
    // faulting store must not write
    assign dm_we      = byte_we & {4{out_valid}} & {4{~exception}};

    assign alu_result = result;
    assign wnum       = r_wnum;
    assign pc         = r_pc;

endmodule

/* design/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,          // from writeback
    input  logic                         in_valid,
    input  logic [exe_pkg::aluop_w-1:0]  in_aluop,
    input  logic                         in_ov_trap,
    input  logic [31:0]                  in_src0,
    input  logic [31:0]                  in_src1,
    input  logic [31:0]                  in_store_data,
    input  exe_pkg::store_kind_t         in_store_kind,
    input  exe_pkg::check_kind_t         in_check_kind,
    input  logic [4:0]                   in_wnum,
    input  logic [31:0]                  in_pc,
    input  logic                         in_exc,
    input  exe_pkg::exc_code_t           in_exc_code,
    input  logic [31:0]                  in_bad_vaddr,
    input  logic                         mem_allowin,
    output logic                         allowin,
    output logic                         out_valid,
    output logic [31:0]                  alu_result,
    output logic [31:0]                  dm_addr,
    output logic [31:0]                  dm_data,
    output logic [3:0]                   dm_we,
    output logic [4:0]                   wnum,
    output logic [31:0]                  pc,
    output logic                         exception,
    output exe_pkg::exc_code_t           exc_code,
    output logic [31:0]                  bad_vaddr
);

    // --------------------
    // stage register fields
    logic                         stage_valid;
    logic [exe_pkg::aluop_w-1:0]  r_aluop;
    logic                         r_ov_trap;
    logic [31:0]                  r_src0;
    logic [31:0]                  r_src1;
    logic [31:0]                  r_store_data;
    exe_pkg::store_kind_t         r_store_kind;
    exe_pkg::check_kind_t         r_check_kind;
    logic [4:0]                   r_wnum;
    logic [31:0]                  r_pc;
    logic                         r_exc;
    exe_pkg::exc_code_t           r_exc_code;
    logic [31:0]                  r_bad_vaddr;

    logic [31:0] result;
    logic        overflow;
    logic [31:0] aligned_data;
    logic [3:0]  byte_we;         // before valid/exception masking

    exe_issue_reg u_issue_reg (
        .clk, .rst, .flush, .in_valid, .mem_allowin,
        .in_aluop, .in_ov_trap, .in_src0, .in_src1, .in_store_data,
        .in_store_kind, .in_check_kind, .in_wnum, .in_pc,
        .in_exc, .in_exc_code, .in_bad_vaddr,
        .allowin, .stage_valid,
        .r_aluop, .r_ov_trap, .r_src0, .r_src1, .r_store_data,
        .r_store_kind, .r_check_kind, .r_wnum, .r_pc,
        .r_exc, .r_exc_code, .r_bad_vaddr
    );

    exe_alu u_alu (
        .aluop    (r_aluop),
        .ov_trap  (r_ov_trap),
        .src0     (r_src0),
        .src1     (r_src1),
        .result   (result),
        .overflow (overflow)
    );

    exe_store_align u_store_align (
        .store_kind (r_store_kind),
        .addr_low   (result[1:0]),     // lane from the computed address
        .store_data (r_store_data),
        .dm_data    (aligned_data),
        .byte_we    (byte_we)
    );

    exe_mem_out u_mem_out (
        .stage_valid, .check_kind (r_check_kind),
        .result, .overflow, .byte_we, .aligned_data,
        .r_wnum, .r_pc, .r_exc, .r_exc_code, .r_bad_vaddr,
        .out_valid, .alu_result, .dm_addr, .dm_data, .dm_we,
        .wnum, .pc, .exception, .exc_code, .bad_vaddr
    );

endmodule

/* bench/exe_stage_tb.sv */
`timescale 1ns/1ps

module exe_stage_tb;

    logic                        clk;
    logic                        rst;
    logic                        flush;
    logic                        in_valid;
    logic                        mem_allowin;
    logic [exe_pkg::aluop_w-1:0] in_aluop;
    logic                        in_ov_trap;
    logic                        in_exc;
    logic [31:0]                 in_src0;
    logic [31:0]                 in_src1;
    logic [31:0]                 in_store_data;
    logic [31:0]                 in_pc;
    logic [31:0]                 in_bad_vaddr;
    logic [4:0]                  in_wnum;
    exe_pkg::store_kind_t        in_store_kind;
    exe_pkg::check_kind_t        in_check_kind;
    exe_pkg::exc_code_t          in_exc_code;
    logic                        allowin;
    logic                        out_valid;
    logic                        exception;
    logic [31:0]                 alu_result;
    logic [31:0]                 dm_addr;
    logic [31:0]                 dm_data;
    logic [31:0]                 pc;
    logic [31:0]                 bad_vaddr;
    logic [3:0]                  dm_we;
    logic [4:0]                  wnum;
    exe_pkg::exc_code_t          exc_code;

    // --------------------
    // table row with stimulus and expected values
    typedef struct {
        logic [exe_pkg::aluop_w-1:0] aluop;
        logic                        ov_trap;
        logic [31:0]                 src0;
        logic [31:0]                 src1;
        logic [31:0]                 sdata;
        exe_pkg::store_kind_t        skind;
        exe_pkg::check_kind_t        ckind;
        logic                        exc_in;
        exe_pkg::exc_code_t          code_in;
        logic [31:0]                 bad_in;
        logic                        do_flush;    // removed while held
        logic [31:0]                 e_res;
        logic [3:0]                  e_we;
        logic [31:0]                 e_data;
        logic                        e_exc;
        exe_pkg::exc_code_t          e_code;
        logic [31:0]                 e_bad;
    } row_t;

    row_t        rows [0:47];
    int          n_rows;
    int          n_flush;
    int          chk_idx = 0;     // next row the checker expects
    int          n_seen = 0;
    int          cycles = 0;
    integer      seed;
    logic        held = 1'b0;     // previous sample was a stall
    logic        just_taken = 1'b0;    // entry accepted at the last edge
    logic [31:0] held_res = '0;
    logic [31:0] held_pc = '0;
    logic [3:0]  held_we = '0;

    exe_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] pc_of(input int k);
        return 32'hbfc00000 + 32'(k) * 4;
    endfunction

    // --------------------
    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, act, exp);
            end_with_failure("an output did not match its expected value");
        end
    endtask

    task automatic check_we(input string name, input logic [3:0] act, input logic [3:0] exp);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s = %b, expected %b", $time, name, act, exp);
            end_with_failure("an output did not match its expected value");
        end
    endtask

    task automatic check_code(input string name, input exe_pkg::exc_code_t act,
                              input exe_pkg::exc_code_t exp);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, act, exp);
            end_with_failure("an output did not match its expected value");
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s = %b, expected %b", $time, name, act, exp);
            end_with_failure("an output did not match its expected value");
        end
    endtask

    // --------------------
    // table building
    task automatic alu_row(input int op, input logic ov, input logic [31:0] s0,
                           input logic [31:0] s1, input logic [31:0] res);
        rows[n_rows].aluop     = '0;
        rows[n_rows].aluop[op] = 1'b1;
        rows[n_rows].ov_trap   = ov;
        rows[n_rows].src0      = s0;
        rows[n_rows].src1      = s1;
        rows[n_rows].sdata     = '0;
        rows[n_rows].skind     = exe_pkg::st_none;
        rows[n_rows].ckind     = exe_pkg::chk_none;
        rows[n_rows].exc_in    = 1'b0;
        rows[n_rows].code_in   = '0;
        rows[n_rows].bad_in    = '0;
        rows[n_rows].do_flush  = 1'b0;
        rows[n_rows].e_res     = res;
        rows[n_rows].e_we      = 4'b0000;
        rows[n_rows].e_data    = '0;
        rows[n_rows].e_exc     = 1'b0;
        rows[n_rows].e_code    = '0;
        rows[n_rows].e_bad     = res;    // address faults report the sum
        n_rows++;
    endtask

    // address 0x1000 plus offset with data word aabbccdd
    task automatic store_row(input exe_pkg::store_kind_t sk, input exe_pkg::check_kind_t ck,
                             input logic [31:0] off, input logic [3:0] we,
                             input logic [31:0] data);
        alu_row(exe_pkg::op_add, 0, 32'h00001000, off, 32'h00001000 + off);
        rows[n_rows-1].sdata  = 32'haabbccdd;
        rows[n_rows-1].skind  = sk;
        rows[n_rows-1].ckind  = ck;
        rows[n_rows-1].e_we   = we;
        rows[n_rows-1].e_data = data;
    endtask

    task automatic load_row(input exe_pkg::check_kind_t ck, input logic [31:0] off);
        alu_row(exe_pkg::op_add, 0, 32'h00001000, off, 32'h00001000 + off);
        rows[n_rows-1].ckind = ck;
    endtask

    task automatic expect_fault(input exe_pkg::exc_code_t code);
        rows[n_rows-1].e_exc  = 1'b1;
        rows[n_rows-1].e_code = code;
    endtask

    task automatic expect_incoming(input exe_pkg::exc_code_t code, input logic [31:0] addr);
        rows[n_rows-1].exc_in  = 1'b1;
        rows[n_rows-1].code_in = code;
        rows[n_rows-1].bad_in  = addr;
        rows[n_rows-1].e_exc   = 1'b1;
        rows[n_rows-1].e_code  = code;
        rows[n_rows-1].e_bad   = addr;
    endtask

    task automatic flush_row();
        rows[n_rows-1].do_flush = 1'b1;
        n_flush++;
    endtask

    task automatic build_table();
        alu_row(exe_pkg::op_sub,  0, 32'd3,        32'd5,        32'hfffffffe);
        alu_row(exe_pkg::op_slt,  0, 32'h80000000, 32'd1,        32'd1);
        alu_row(exe_pkg::op_sltu, 0, 32'h80000000, 32'd1,        32'd0);
        alu_row(exe_pkg::op_and,  0, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h00f0f000);
        alu_row(exe_pkg::op_nor,  0, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h000f000f);
        alu_row(exe_pkg::op_or,   0, 32'hf0f0ff00, 32'h0ff0f0f0, 32'hfff0fff0);
        alu_row(exe_pkg::op_xor,  0, 32'hf0f0ff00, 32'h0ff0f0f0, 32'hff000ff0);
        alu_row(exe_pkg::op_sll,  0, 32'd4,        32'h80000001, 32'h00000010);
        alu_row(exe_pkg::op_srl,  0, 32'd4,        32'h80000010, 32'h08000001);
        alu_row(exe_pkg::op_sra,  0, 32'd4,        32'h80000010, 32'hf8000001);
        alu_row(exe_pkg::op_lui,  0, 32'd0,        32'h1234abcd, 32'habcd0000);
        alu_row(exe_pkg::op_add,  1, 32'h7fffffff, 32'd1,        32'h80000000);
        rows[n_rows-1].skind = exe_pkg::st_sw;    // lanes enabled but overflow blocks the write
        expect_fault(exe_pkg::exc_ov);
        alu_row(exe_pkg::op_add,  0, 32'h7fffffff, 32'd1,        32'h80000000);
        alu_row(exe_pkg::op_or,   0, 32'd1,        32'd2,        32'd3);
        flush_row();
        store_row(exe_pkg::st_sb,  exe_pkg::chk_none, 32'd0, 4'b0001, 32'hdddddddd);
        store_row(exe_pkg::st_sb,  exe_pkg::chk_none, 32'd1, 4'b0010, 32'hdddddddd);
        store_row(exe_pkg::st_sb,  exe_pkg::chk_none, 32'd2, 4'b0100, 32'hdddddddd);
        store_row(exe_pkg::st_sb,  exe_pkg::chk_none, 32'd7, 4'b1000, 32'hdddddddd);
        store_row(exe_pkg::st_sh,  exe_pkg::chk_store_half, 32'd0, 4'b0011, 32'hccddccdd);
        store_row(exe_pkg::st_sh,  exe_pkg::chk_store_half, 32'd2, 4'b1100, 32'hccddccdd);
        store_row(exe_pkg::st_sw,  exe_pkg::chk_store_word, 32'd4, 4'b1111, 32'haabbccdd);
        store_row(exe_pkg::st_swl, exe_pkg::chk_none, 32'd0, 4'b0001, 32'h000000aa);
        store_row(exe_pkg::st_swl, exe_pkg::chk_none, 32'd1, 4'b0011, 32'h0000aabb);
        store_row(exe_pkg::st_swl, exe_pkg::chk_none, 32'd2, 4'b0111, 32'h00aabbcc);
        store_row(exe_pkg::st_swl, exe_pkg::chk_none, 32'd3, 4'b1111, 32'haabbccdd);
        store_row(exe_pkg::st_swr, exe_pkg::chk_none, 32'd0, 4'b1111, 32'haabbccdd);
        store_row(exe_pkg::st_swr, exe_pkg::chk_none, 32'd1, 4'b1110, 32'hbbccdd00);
        store_row(exe_pkg::st_swr, exe_pkg::chk_none, 32'd2, 4'b1100, 32'hccdd0000);
        store_row(exe_pkg::st_swr, exe_pkg::chk_none, 32'd3, 4'b1000, 32'hdd000000);
        // misaligned accesses fault and never write
        store_row(exe_pkg::st_sh,  exe_pkg::chk_store_half, 32'd3, 4'b0000, 32'hccddccdd);
        expect_fault(exe_pkg::exc_ades);
        store_row(exe_pkg::st_sw,  exe_pkg::chk_store_word, 32'd1, 4'b0000, 32'haabbccdd);
        expect_fault(exe_pkg::exc_ades);
        load_row(exe_pkg::chk_load_half, 32'd1);
        expect_fault(exe_pkg::exc_adel);
        load_row(exe_pkg::chk_load_word, 32'd2);
        expect_fault(exe_pkg::exc_adel);
        // upstream exception wins over overflow and address error
        alu_row(exe_pkg::op_add,  1, 32'h7fffffff, 32'd1,        32'h80000000);
        expect_incoming(5'd10, 32'hbfc00180);
        store_row(exe_pkg::st_sw,  exe_pkg::chk_store_word, 32'd2, 4'b0000, 32'haabbccdd);
        expect_incoming(5'd8, 32'h00400040);
    endtask

    task automatic compare_row(input int k);
        check_word("alu_result", alu_result, rows[k].e_res);
        check_word("dm_addr", dm_addr, rows[k].e_res);
        check_we("dm_we", dm_we, rows[k].e_we);
        if (rows[k].e_we != 4'b0000) begin
            check_word("dm_data", dm_data, rows[k].e_data);
        end
        check_bit("exception", exception, rows[k].e_exc);
        if (rows[k].e_exc) begin
            check_code("exc_code", exc_code, rows[k].e_code);
            check_word("bad_vaddr", bad_vaddr, rows[k].e_bad);
        end
        check_word("wnum", {27'd0, wnum}, {27'd0, 5'(k)});
        check_word("pc", pc, pc_of(k));
    endtask

    task automatic drive_row(input int k);
        in_valid      = 1'b1;
        in_aluop      = rows[k].aluop;
        in_ov_trap    = rows[k].ov_trap;
        in_src0       = rows[k].src0;
        in_src1       = rows[k].src1;
        in_store_data = rows[k].sdata;
        in_store_kind = rows[k].skind;
        in_check_kind = rows[k].ckind;
        in_exc        = rows[k].exc_in;
        in_exc_code   = rows[k].code_in;
        in_bad_vaddr  = rows[k].bad_in;
        in_wnum       = 5'(k);
        in_pc         = pc_of(k);
    endtask

    // --------------------
    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (just_taken) begin
                check_bit("out_valid after accept", out_valid, 1'b1);
                just_taken = 1'b0;
            end
            if (held && out_valid) begin
                check_word("alu_result while stalled", alu_result, held_res);
                check_word("pc while stalled", pc, held_pc);
                check_we("dm_we while stalled", dm_we, held_we);
            end
            if (out_valid && !mem_allowin) begin
                check_bit("allowin under back-pressure", allowin, 1'b0);
            end else begin
                check_bit("allowin", allowin, 1'b1);
            end
            if (out_valid && mem_allowin) begin    // leaves at the next edge
                while (chk_idx < n_rows && rows[chk_idx].do_flush) begin
                    chk_idx++;
                end
                if (chk_idx >= n_rows) begin
                    end_with_failure("an entry left the stage after the last table row");
                end else begin
                    compare_row(chk_idx);
                    chk_idx++;
                    n_seen++;
                end
            end
            held     = out_valid && !mem_allowin;
            held_res = alu_result;
            held_pc  = pc;
            held_we  = dm_we;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 20 * n_rows + 50) begin
            end_with_failure("timeout, the table did not drain within the cycle limit");
        end
    end

    // --------------------
    initial begin
        logic taken;
        seed          = 35176;
        rst           = 1'b1;
        flush         = 1'b0;
        in_valid      = 1'b0;
        mem_allowin   = 1'b0;
        in_aluop      = '0;
        in_ov_trap    = 1'b0;
        in_src0       = '0;
        in_src1       = '0;
        in_store_data = '0;
        in_store_kind = exe_pkg::st_none;
        in_check_kind = exe_pkg::chk_none;
        in_wnum       = '0;
        in_pc         = '0;
        in_exc        = 1'b0;
        in_exc_code   = '0;
        in_bad_vaddr  = '0;
        n_rows        = 0;
        n_flush       = 0;
        build_table();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_we("dm_we", dm_we, 4'b0000);
        @(posedge clk);
        #1;
        for (int i = 0; i < n_rows; i++) begin
            drive_row(i);
            do begin
                mem_allowin = ({$random(seed)} % 10) < 7;    // about 70% ready
                @(negedge clk);
                taken = allowin;
                @(posedge clk);
                #1;
            end while (!taken);
            just_taken = 1'b1;
            if (rows[i].do_flush) begin
                in_valid    = 1'b0;
                mem_allowin = 1'b0;    // keep it held until the flush hits
                flush       = 1'b1;
                @(posedge clk);
                #1;
                flush = 1'b0;
            end
        end
        in_valid = 1'b0;
        while (chk_idx < n_rows) begin
            mem_allowin = ({$random(seed)} % 10) < 7;
            @(posedge clk);
            #1;
        end
        repeat (4) begin    // nothing more should come out
            mem_allowin = 1'b1;
            @(posedge clk);
            #1;
        end
        if (n_seen == n_rows - n_flush) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            end_with_failure("the number of entries that left the stage is wrong");
        end
    end

endmodule

/* all.f */
design/exe_pkg.sv
design/exe_issue_reg.sv
design/exe_alu.sv
design/exe_store_align.sv
design/exe_mem_out.sv
design/exe_stage.sv
bench/exe_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module exe_stage_tb -o exe_sim \
    && ./obj_dir/exe_sim | tee /dev/stderr | grep -q -F "*** TEST PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
